// ==== aud.f ====
aud_pkg.sv
aud_transport.sv
aud_recorder.sv
sample_ram.sv
aud_fetch.sv
aud_sample_fifo.sv
aud_player.sv
aud_top.sv
tb_aud_top.sv

// ==== aud_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module aud_fetch import aud_pkg::*; (
    input  wire logic        i_bclk,
    input  wire logic        i_rst_n,
    input  wire play_cmd_t   i_cmd,
    input  wire logic        i_credit,
    input  wire pcm_sample_t i_rd_data,
    output logic [ADDR_W-1:0] o_rd_addr,
    output sample_xfer_t     o_xfer,
    output logic             o_done
);

    logic                running_r;
    logic                pend_r;     // read in flight
    logic [ADDR_W:0]     addr_r;
    logic [ADDR_W:0]     len_r;
    logic [CREDIT_W-1:0] credit_r;
    logic                issue;

    assign issue       = running_r && (addr_r != len_r) && (credit_r != '0);
    assign o_rd_addr   = addr_r[ADDR_W-1:0];
    assign o_xfer.valid = pend_r;
    assign o_xfer.data  = i_rd_data;
    assign o_done      = pend_r && (addr_r == len_r);  // last sample leaving

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            running_r <= 1'b0;
            pend_r    <= 1'b0;
            addr_r    <= '0;
            len_r     <= '0;
            credit_r  <= CREDIT_W'(FIFO_DEPTH);
        end else if (i_cmd.stop) begin
            running_r <= 1'b0;
            pend_r    <= 1'b0;
        end else if (i_cmd.start) begin
            running_r <= 1'b1;
            pend_r    <= 1'b0;
            addr_r    <= '0;
            len_r     <= i_cmd.len;
            credit_r  <= CREDIT_W'(FIFO_DEPTH);  // FIFO flushed alongside
        end else begin
            pend_r   <= issue;
            credit_r <= credit_r - CREDIT_W'(issue) + CREDIT_W'(i_credit);
            if (issue) begin
                addr_r <= addr_r + 1'b1;
            end
            if (o_done) begin
                running_r <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== aud_pkg.sv ====
`default_nettype none

package aud_pkg;

    // sample and memory geometry
    localparam int SAMPLE_W = 16;
    localparam int ADDR_W   = 8;
    localparam int MEM_SIZE = 1 << ADDR_W;

    // player FIFO, depth must be a power of two
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int CREDIT_W   = $clog2(FIFO_DEPTH + 1);

    typedef logic signed [SAMPLE_W-1:0] pcm_sample_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        pcm_sample_t       data;
    } ram_wr_t;

    // one-cycle pulses to the recorder
    typedef struct packed {
        logic start;
        logic pause;
        logic stop;
    } rec_cmd_t;

    typedef struct packed {
        logic            start;
        logic            stop;
        logic [ADDR_W:0] len;   // recorded samples, up to MEM_SIZE
    } play_cmd_t;

    typedef struct packed {
        logic        valid;
        pcm_sample_t data;
    } sample_xfer_t;

endpackage

`default_nettype wire

// ==== aud_player.sv ====
`timescale 1ns/10ps
`default_nettype none

module aud_player import aud_pkg::*; (
    input  wire logic         i_bclk,
    input  wire logic         i_rst_n,
    input  wire logic         i_daclrck,
    input  wire logic         i_flush,
    input  wire sample_xfer_t i_xfer,
    output logic              o_credit,
    output logic              o_aud_dacdat
);

    typedef enum logic [1:0] {S_IDLE, S_DATAL, S_IDLE2, S_DATAR} play_state_e;

    play_state_e state_r, state_w;
    logic [3:0]  cnt_r, cnt_w;
    logic        dacdat_r, dacdat_w;
    logic        credit_r;
    logic        left_start;
    logic        pop;
    logic        fifo_empty;
    pcm_sample_t fifo_head;
    pcm_sample_t sample_r;     // held for both slots

    aud_sample_fifo u_fifo (
        .i_bclk  (i_bclk),
        .i_rst_n (i_rst_n),
        .i_flush (i_flush),
        .i_push  (i_xfer),
        .i_pop   (pop),
        .o_head  (fifo_head),
        .o_empty (fifo_empty)
    );

    assign left_start   = (state_r == S_IDLE) && !i_daclrck;
    assign pop          = left_start && !fifo_empty && !i_flush;
    assign o_credit     = credit_r;
    assign o_aud_dacdat = dacdat_r;

    always_comb begin
        state_w  = state_r;
        cnt_w    = cnt_r;
        dacdat_w = 1'b0;

        case (state_r)
            S_IDLE: begin
                if (!i_daclrck) begin  // left slot
                    state_w = S_DATAL;
                end
            end
            S_DATAL, S_DATAR: begin
                dacdat_w = sample_r[cnt_r];
                if (cnt_r != '0) begin
                    cnt_w = cnt_r - 1'b1;
                end else begin
                    cnt_w   = 4'hf;
                    state_w = (state_r == S_DATAL) ? S_IDLE2 : S_IDLE;
                end
            end
            S_IDLE2: begin
                if (i_daclrck) begin  // right slot
                    state_w = S_DATAR;
                end
            end
            default: state_w = S_IDLE;
        endcase
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r  <= S_IDLE;
            cnt_r    <= 4'hf;
            dacdat_r <= 1'b0;
            credit_r <= 1'b0;
        end else begin
            state_r  <= state_w;
            cnt_r    <= cnt_w;
            dacdat_r <= dacdat_w;
            credit_r <= pop;  // one credit back per pop
        end
    end

    always_ff @(posedge i_bclk) begin
        if (i_flush) begin
            sample_r <= '0;
        end else if (left_start) begin
            sample_r <= fifo_empty ? pcm_sample_t'(0) : fifo_head;  // underrun plays silence
        end
    end

endmodule

`default_nettype wire

// ==== aud_recorder.sv ====
`timescale 1ns/10ps
`default_nettype none

module aud_recorder import aud_pkg::*; (
    input  wire logic     i_bclk,
    input  wire logic     i_rst_n,
    input  wire logic     i_adclrck,
    input  wire logic     i_adcdat,
    input  wire rec_cmd_t i_cmd,
    output ram_wr_t       o_wr
);

    typedef enum logic [1:0] {S_IDLE, S_WAIT, S_SHIFT, S_PAUSE} rec_state_e;

    rec_state_e        state_r, state_w;
    logic [3:0]        cnt_r, cnt_w;
    logic [ADDR_W-1:0] addr_r, addr_w;
    logic              pend_r, pend_w;      // pause seen mid-sample
    logic              wr_valid_r, wr_valid_w;
    logic              shift_en;
    pcm_sample_t       shift_r;

    // addr_r moves on only after the write has gone out
    assign o_wr.valid = wr_valid_r;
    assign o_wr.addr  = addr_r;
    assign o_wr.data  = shift_r;

    always_comb begin
        state_w    = state_r;
        cnt_w      = cnt_r;
        addr_w     = wr_valid_r ? addr_r + 1'b1 : addr_r;
        pend_w     = pend_r;
        wr_valid_w = 1'b0;
        shift_en   = 1'b0;

        if (i_cmd.stop) begin
            state_w = S_IDLE;  // partial sample dropped
            pend_w  = 1'b0;
        end else begin
            case (state_r)
                S_IDLE: begin
                    if (i_cmd.start) begin
                        state_w = S_WAIT;
                        cnt_w   = '0;
                        addr_w  = '0;
                    end
                end
                S_WAIT: begin
                    if (i_cmd.pause) begin
                        state_w = S_PAUSE;
                    end else if (i_adclrck) begin  // right half seen
                        state_w = S_SHIFT;
                        cnt_w   = '0;
                    end
                end
                S_SHIFT: begin
                    if (i_cmd.pause && cnt_r == '0) begin
                        state_w = S_PAUSE;
                    end else begin
                        if (i_cmd.pause) begin
                            pend_w = 1'b1;
                        end
                        if (!i_adclrck) begin
                            shift_en = 1'b1;
                            cnt_w    = cnt_r + 1'b1;
                            if (cnt_r == 4'hf) begin
                                wr_valid_w = 1'b1;
                                state_w    = (pend_r || i_cmd.pause) ? S_PAUSE : S_WAIT;
                                pend_w     = 1'b0;
                            end
                        end
                    end
                end
                S_PAUSE: begin
                    if (i_cmd.start) begin
                        state_w = S_WAIT;
                    end
                end
                default: state_w = S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r    <= S_IDLE;
            cnt_r      <= '0;
            addr_r     <= '0;
            pend_r     <= 1'b0;
            wr_valid_r <= 1'b0;
        end else begin
            state_r    <= state_w;
            cnt_r      <= cnt_w;
            addr_r     <= addr_w;
            pend_r     <= pend_w;
            wr_valid_r <= wr_valid_w;
        end
    end

    always_ff @(posedge i_bclk) begin
        if (shift_en) begin
            shift_r <= {shift_r[SAMPLE_W-2:0], i_adcdat};  // msb first
        end
    end

endmodule

`default_nettype wire

// ==== aud_sample_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module aud_sample_fifo import aud_pkg::*; (
    input  wire logic         i_bclk,
    input  wire logic         i_rst_n,
    input  wire logic         i_flush,
    input  wire sample_xfer_t i_push,
    input  wire logic         i_pop,
    output pcm_sample_t       o_head,
    output logic              o_empty
);

    pcm_sample_t           mem [FIFO_DEPTH];
    logic [FIFO_PTR_W:0]   wr_ptr_r;   // extra bit tells full from empty
    logic [FIFO_PTR_W:0]   rd_ptr_r;

    assign o_empty = (wr_ptr_r == rd_ptr_r);
    assign o_head  = mem[rd_ptr_r[FIFO_PTR_W-1:0]];

    // sender holds a credit per push, so no full check here
    always_ff @(posedge i_bclk) begin
        if (i_push.valid) begin
            mem[wr_ptr_r[FIFO_PTR_W-1:0]] <= i_push.data;
        end
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
        end else if (i_flush) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
        end else begin
            if (i_push.valid) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (i_pop && !o_empty) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== aud_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module aud_top import aud_pkg::*; (
    input  wire logic        i_bclk,
    input  wire logic        i_rst_n,
    input  wire logic        i_daclrck,
    input  wire logic        i_adclrck,
    input  wire logic        i_adcdat,
    input  wire logic        i_rec,
    input  wire logic        i_play,
    input  wire logic        i_pause,
    input  wire logic        i_stop,
    output logic             o_aud_dacdat,
    output logic             o_rec_active,
    output logic             o_play_active,
    output logic [ADDR_W:0]  o_rec_count
);

    rec_cmd_t          rec_cmd;
    play_cmd_t         play_cmd;
    ram_wr_t           wr;
    logic              done;
    logic [ADDR_W-1:0] rd_addr;
    pcm_sample_t       rd_data;
    sample_xfer_t      xfer;
    logic              credit;

    aud_transport u_transport (
        .i_bclk        (i_bclk),
        .i_rst_n       (i_rst_n),
        .i_rec         (i_rec),
        .i_play        (i_play),
        .i_pause       (i_pause),
        .i_stop        (i_stop),
        .i_wr          (wr),
        .i_done        (done),
        .o_rec_cmd     (rec_cmd),
        .o_play_cmd    (play_cmd),
        .o_rec_active  (o_rec_active),
        .o_play_active (o_play_active),
        .o_rec_count   (o_rec_count)
    );

    aud_recorder u_recorder (
        .i_bclk    (i_bclk),
        .i_rst_n   (i_rst_n),
        .i_adclrck (i_adclrck),
        .i_adcdat  (i_adcdat),
        .i_cmd     (rec_cmd),
        .o_wr      (wr)
    );

    sample_ram u_ram (
        .i_bclk    (i_bclk),
        .i_wr      (wr),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    aud_fetch u_fetch (
        .i_bclk    (i_bclk),
        .i_rst_n   (i_rst_n),
        .i_cmd     (play_cmd),
        .i_credit  (credit),
        .i_rd_data (rd_data),
        .o_rd_addr (rd_addr),
        .o_xfer    (xfer),
        .o_done    (done)
    );

    aud_player u_player (
        .i_bclk       (i_bclk),
        .i_rst_n      (i_rst_n),
        .i_daclrck    (i_daclrck),
        .i_flush      (play_cmd.start | play_cmd.stop),
        .i_xfer       (xfer),
        .o_credit     (credit),
        .o_aud_dacdat (o_aud_dacdat)
    );

endmodule

`default_nettype wire

// ==== aud_transport.sv ====
`timescale 1ns/10ps
`default_nettype none

module aud_transport import aud_pkg::*; (
    input  wire logic            i_bclk,
    input  wire logic            i_rst_n,
    input  wire logic            i_rec,
    input  wire logic            i_play,
    input  wire logic            i_pause,
    input  wire logic            i_stop,
    input  wire ram_wr_t         i_wr,
    input  wire logic            i_done,
    output rec_cmd_t             o_rec_cmd,
    output play_cmd_t            o_play_cmd,
    output logic                 o_rec_active,
    output logic                 o_play_active,
    output logic [ADDR_W:0]      o_rec_count
);

    typedef enum logic [1:0] {T_IDLE, T_REC, T_RPAUSE, T_PLAY} xport_state_e;

    xport_state_e    state_r, state_w;
    logic [ADDR_W:0] count_r;
    logic            sat;
    logic            clr_count;

    assign sat           = (count_r == (ADDR_W+1)'(MEM_SIZE));  // memory full
    assign o_rec_active  = (state_r == T_REC) || (state_r == T_RPAUSE);
    assign o_play_active = (state_r == T_PLAY);
    assign o_rec_count   = count_r;

    always_comb begin
        state_w          = state_r;
        o_rec_cmd        = '0;
        o_play_cmd.start = 1'b0;
        o_play_cmd.stop  = 1'b0;
        o_play_cmd.len   = count_r;
        clr_count        = 1'b0;

        case (state_r)
            T_IDLE: begin
                if (i_rec) begin
                    o_rec_cmd.start = 1'b1;
                    clr_count       = 1'b1;
                    state_w         = T_REC;
                end else if (i_play && count_r != '0) begin  // nothing to play otherwise
                    o_play_cmd.start = 1'b1;
                    state_w          = T_PLAY;
                end
            end
            T_REC: begin
                if (i_stop || sat) begin
                    o_rec_cmd.stop = 1'b1;
                    state_w        = T_IDLE;
                end else if (i_pause) begin
                    o_rec_cmd.pause = 1'b1;
                    state_w         = T_RPAUSE;
                end
            end
            T_RPAUSE: begin
                if (i_stop || sat) begin
                    o_rec_cmd.stop = 1'b1;
                    state_w        = T_IDLE;
                end else if (i_rec || i_pause) begin  // resume, count kept
                    o_rec_cmd.start = 1'b1;
                    state_w         = T_REC;
                end
            end
            T_PLAY: begin
                if (i_stop) begin
                    o_play_cmd.stop = 1'b1;
                    state_w         = T_IDLE;
                end else if (i_done) begin
                    state_w = T_IDLE;
                end
            end
            default: state_w = T_IDLE;
        endcase
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= T_IDLE;
            count_r <= '0;
        end else begin
            state_r <= state_w;
            if (clr_count) begin
                count_r <= '0;
            end else if (i_wr.valid && !sat) begin
                count_r <= count_r + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sample_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module sample_ram import aud_pkg::*; (
    input  wire logic              i_bclk,
    input  wire ram_wr_t           i_wr,
    input  wire logic [ADDR_W-1:0] i_rd_addr,
    output pcm_sample_t            o_rd_data
);

    pcm_sample_t mem [MEM_SIZE];

    always_ff @(posedge i_bclk) begin
        if (i_wr.valid) begin
            mem[i_wr.addr] <= i_wr.data;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge i_bclk) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

// ==== tb_aud_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_aud_top import aud_pkg::*; ();

    localparam int MAX_FRAMES  = 1024;
    localparam int TEST_FRAMES = 400;   // all tests together with some margin
    localparam int TIMEOUT_CYC = TEST_FRAMES * 64 * 2;
    localparam int BTN_REC     = 0;
    localparam int BTN_PLAY    = 1;
    localparam int BTN_PAUSE   = 2;
    localparam int BTN_STOP    = 3;
    localparam logic [31:0] SEED = 32'he22ee7ee;

    logic            i_bclk;
    logic            i_rst_n;
    logic            i_daclrck;
    logic            i_adclrck;
    logic            i_adcdat;
    logic            i_rec;
    logic            i_play;
    logic            i_pause;
    logic            i_stop;
    logic            o_aud_dacdat;
    logic            o_rec_active;
    logic            o_play_active;
    logic [ADDR_W:0] o_rec_count;

    int          pos;         // cycle within the 64-cycle frame
    int          frame_no;
    pcm_sample_t adc_word [MAX_FRAMES];
    pcm_sample_t exp_word [MAX_FRAMES];   // expected dac word per frame for both slots
    int          dec_frame_q [$];
    pcm_sample_t dec_left_q [$];
    pcm_sample_t dec_right_q [$];
    pcm_sample_t cap_l;
    pcm_sample_t cap_r;
    int          cmp_err;
    int          chk_err;
    int          pass_cnt;
    int          fail_cnt;
    int          cyc;

    aud_top dut0 (
        .i_bclk        (i_bclk),
        .i_rst_n       (i_rst_n),
        .i_daclrck     (i_daclrck),
        .i_adclrck     (i_adclrck),
        .i_adcdat      (i_adcdat),
        .i_rec         (i_rec),
        .i_play        (i_play),
        .i_pause       (i_pause),
        .i_stop        (i_stop),
        .o_aud_dacdat  (o_aud_dacdat),
        .o_rec_active  (o_rec_active),
        .o_play_active (o_play_active),
        .o_rec_count   (o_rec_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // k-th played sample comes from the recorded frames past the paused run
    function automatic pcm_sample_t ref_sample(input int first, input int skip_lo,
                                               input int skip_hi, input int len, input int k);
        int f;
        if (k >= len) begin
            return '0;   // fifo drained so silence
        end
        f = first + k;
        if (skip_hi >= skip_lo && f >= skip_lo) begin
            f = f + (skip_hi - skip_lo + 1);
        end
        return adc_word[f];
    endfunction

    initial begin
        i_bclk = 1'b0;
        forever #50 i_bclk = ~i_bclk;
    end

    // codec model drives lrck low for 32 cycles then high for 32
    initial begin : codec
        logic [31:0] rng;
        rng      = SEED;
        pos      = 0;
        frame_no = 0;
        for (int i = 0; i < MAX_FRAMES; i++) begin
            rng         = xorshift32(rng);
            adc_word[i] = rng[SAMPLE_W-1:0];
            exp_word[i] = '0;
        end
        forever begin
            @(posedge i_bclk);
            rng = xorshift32(rng);
            i_adclrck <= (pos >= 32);
            i_daclrck <= (pos >= 32);
            if (pos < SAMPLE_W) begin
                i_adcdat <= adc_word[frame_no][SAMPLE_W-1-pos];  // msb first
            end else begin
                i_adcdat <= rng[0];
            end
            if (pos == 63) begin
                pos      <= 0;
                frame_no <= frame_no + 1;
            end else begin
                pos <= pos + 1;
            end
        end
    end

    // bit 15 shows two cycles after the player sees the lrck level
    always @(posedge i_bclk) begin
        if (pos >= 3 && pos <= 18) begin
            cap_l <= {cap_l[SAMPLE_W-2:0], o_aud_dacdat};
        end
        if (pos >= 35 && pos <= 50) begin
            cap_r <= {cap_r[SAMPLE_W-2:0], o_aud_dacdat};
        end
        if (pos == 51) begin
            dec_frame_q.push_back(frame_no);
            dec_left_q.push_back(cap_l);
            dec_right_q.push_back(cap_r);
        end
    end

    always @(negedge i_bclk) begin : compare
        int          f;
        pcm_sample_t l;
        pcm_sample_t r;
        while (dec_frame_q.size() > 0) begin
            f = dec_frame_q.pop_front();
            l = dec_left_q.pop_front();
            r = dec_right_q.pop_front();
            if (f > 0) begin   // frame 0 overlaps reset
                assert (l === exp_word[f]) else begin
                    $display("error at %0t: o_aud_dacdat left word, frame %0d, got %h expected %h",
                             $time, f, l, exp_word[f]);
                    cmp_err++;
                end
                assert (r === exp_word[f]) else begin
                    $display("error at %0t: o_aud_dacdat right word, frame %0d, got %h expected %h",
                             $time, f, r, exp_word[f]);
                    cmp_err++;
                end
            end
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        assert (got === expected) else begin
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, expected);
            chk_err++;
        end
    endtask

    task automatic next_slot();
        @(posedge i_bclk);
        while (pos != 55) begin
            @(posedge i_bclk);
        end
    endtask

    task automatic skip_frames(input int n);
        repeat (n) next_slot();
    endtask

    task automatic press_button(input int btn);
        case (btn)
            BTN_REC:   i_rec   <= 1'b1;
            BTN_PLAY:  i_play  <= 1'b1;
            BTN_PAUSE: i_pause <= 1'b1;
            default:   i_stop  <= 1'b1;
        endcase
        @(posedge i_bclk);
        i_rec   <= 1'b0;
        i_play  <= 1'b0;
        i_pause <= 1'b0;
        i_stop  <= 1'b0;
    endtask

    task automatic start_play(input int first, input int skip_lo, input int skip_hi,
                              input int len, output int p);
        next_slot();
        p = frame_no;
        press_button(BTN_PLAY);
        for (int k = 0; k <= len; k++) begin
            exp_word[p + 1 + k] = ref_sample(first, skip_lo, skip_hi, len, k);
        end
        @(negedge i_bclk);
        check_val("o_play_active", o_play_active, 1);
    endtask

    task automatic finish_play(input int p, input int len);
        while (o_play_active) begin
            @(negedge i_bclk);
        end
        while (frame_no <= p + len + 1) begin  // fifo still drains after done
            next_slot();
        end
        @(negedge i_bclk);
        check_val("o_play_active", o_play_active, 0);
    endtask

    task automatic report_test(input string name, input int err_before);
        if (cmp_err + chk_err == err_before) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, cmp_err + chk_err - err_before);
        end
    endtask

    initial begin : stimulus
        int p;
        int first;
        int base;
        i_rst_n   = 1'b0;
        i_daclrck = 1'b0;
        i_adclrck = 1'b0;
        i_adcdat  = 1'b0;
        i_rec     = 1'b0;
        i_play    = 1'b0;
        i_pause   = 1'b0;
        i_stop    = 1'b0;
        cmp_err   = 0;
        chk_err   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        repeat (2) @(posedge i_bclk);
        i_rst_n <= 1'b1;

        base = 0;
        @(negedge i_bclk);
        check_val("o_aud_dacdat", o_aud_dacdat, 0);
        check_val("o_rec_active", o_rec_active, 0);
        check_val("o_play_active", o_play_active, 0);
        check_val("o_rec_count", o_rec_count, 0);
        report_test("reset_state", base);

        base = cmp_err + chk_err;
        next_slot();
        first = frame_no + 1;
        press_button(BTN_REC);
        @(negedge i_bclk);
        check_val("o_rec_active", o_rec_active, 1);
        skip_frames(20);
        press_button(BTN_STOP);
        @(negedge i_bclk);
        check_val("o_rec_count", o_rec_count, 20);
        check_val("o_rec_active", o_rec_active, 0);
        start_play(first, 0, -1, 20, p);
        finish_play(p, 20);
        report_test("record_play", base);

        base = cmp_err + chk_err;
        next_slot();
        first = frame_no + 1;
        press_button(BTN_REC);
        skip_frames(5);
        press_button(BTN_PAUSE);
        skip_frames(3);
        press_button(BTN_REC);     // resume
        skip_frames(7);
        press_button(BTN_STOP);
        @(negedge i_bclk);
        check_val("o_rec_count", o_rec_count, 12);
        start_play(first, first + 5, first + 7, 12, p);
        finish_play(p, 12);
        report_test("pause_resume", base);

        base = cmp_err + chk_err;
        start_play(first, first + 5, first + 7, 12, p);
        skip_frames(5);
        press_button(BTN_STOP);
        for (int f = p + 6; f <= p + 13; f++) begin
            exp_word[f] = '0;
        end
        @(negedge i_bclk);
        check_val("o_play_active", o_play_active, 0);
        skip_frames(3);
        start_play(first, first + 5, first + 7, 12, p);
        finish_play(p, 12);
        report_test("stop_during_play", base);

        base = cmp_err + chk_err;
        start_play(first, first + 5, first + 7, 12, p);
        skip_frames(3);
        press_button(BTN_REC);
        @(negedge i_bclk);
        check_val("o_rec_active", o_rec_active, 0);
        finish_play(p, 12);
        check_val("o_rec_count", o_rec_count, 12);
        next_slot();
        press_button(BTN_REC);
        skip_frames(3);
        press_button(BTN_PLAY);
        @(negedge i_bclk);
        check_val("o_play_active", o_play_active, 0);
        check_val("o_rec_active", o_rec_active, 1);
        skip_frames(3);
        press_button(BTN_STOP);
        @(negedge i_bclk);
        check_val("o_rec_count", o_rec_count, 6);
        report_test("mutual_exclusion", base);

        base = cmp_err + chk_err;
        next_slot();
        press_button(BTN_REC);
        skip_frames(MEM_SIZE - 1);
        @(negedge i_bclk);
        check_val("o_rec_count", o_rec_count, MEM_SIZE - 1);
        check_val("o_rec_active", o_rec_active, 1);
        skip_frames(2);
        @(negedge i_bclk);
        check_val("o_rec_count", o_rec_count, MEM_SIZE);
        check_val("o_rec_active", o_rec_active, 0);
        report_test("capacity", base);

        $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt,
                 cmp_err + chk_err);
        if (fail_cnt == 0 && cmp_err + chk_err == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        cyc = 0;
        while (cyc < TIMEOUT_CYC) begin
            @(posedge i_bclk);
            cyc++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
